/* fmul_top.f */
+incdir+tb
hdl/fmul_pkg.sv
hdl/fmul_lead0.sv
hdl/fmul_stage_reg.sv
hdl/fmul_unpack.sv
hdl/fmul_round.sv
hdl/fmul_top.sv
tb/fmul_tb.sv

/* Bender.yml */
package:
  name: fmul

sources:
  - files:
      - hdl/fmul_pkg.sv
      - hdl/fmul_lead0.sv
      - hdl/fmul_stage_reg.sv
      - hdl/fmul_unpack.sv
      - hdl/fmul_round.sv
      - hdl/fmul_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/fmul_tb.sv

/* tb/fmul_ref.svh */
/* testbench reference model, an lfsr bit source plus a behavioral
   single-precision multiply done in integer arithmetic */
`ifndef FMUL_REF_SVH
`define FMUL_REF_SVH

// 16 bit fibonacci lfsr, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // new bit enters at the lsb
endfunction

// expected {overflow, inexact, word} for one multiply
function automatic logic [33:0] ref_fmul(input fmul_word_t a, input fmul_word_t b);
	logic   sgn, inf_a, inf_b, zero_a, zero_b;
	longint ma, mb, p, q, rem, half, word;
	int     ea, eb, k, te, s;
	sgn    = a.sign ^ b.sign;
	inf_a  = (a.exp == 8'hff);   // nan already filtered below
	inf_b  = (b.exp == 8'hff);
	zero_a = (a.exp == 8'h00) && (a.frac == '0);
	zero_b = (b.exp == 8'h00) && (b.frac == '0);
	if ((inf_a && a.frac != '0) || (inf_b && b.frac != '0))
		return {2'b00, QNAN_WORD};
	if ((inf_a && zero_b) || (zero_a && inf_b))
		return {2'b00, QNAN_WORD};   // invalid
	if (inf_a || inf_b)
		return {2'b00, sgn, 8'hff, 23'h0};
	if (zero_a || zero_b)
		return {2'b00, sgn, 31'h0};
	// value of an operand is m * 2^(e - 150), denormals use e = 1
	ea = (a.exp == 8'h00) ? 1 : int'(a.exp);
	eb = (b.exp == 8'h00) ? 1 : int'(b.exp);
	ma = (a.exp == 8'h00) ? longint'(a.frac) : longint'(a.frac) + 64'd8388608;
	mb = (b.exp == 8'h00) ? longint'(b.frac) : longint'(b.frac) + 64'd8388608;
	p  = ma * mb;   // product scaled by 2^(ea + eb - 300)
	k  = 0;
	for (int i = 0; i < 48; i++) begin
		if (p[i])
			k = i;   // msb position
	end
	te = k + ea + eb - 173;   // biased exponent of the msb
	if (te < 1)
		te = 1;   // gradual underflow keeps the denormal scale
	s = te - ea - eb + 150;   // product bits below the result lsb
	rem = 0;
	if (s <= 0) begin
		q = p << (-s);
	end else if (s > 60) begin
		q   = 0;
		rem = p;   // all of it is discarded, below half
	end else begin
		q    = p >> s;
		rem  = p & ((64'd1 << s) - 64'd1);
		half = 64'd1 << (s - 1);
		if (rem > half || (rem == half && q[0]))
			q = q + 1;   // nearest, ties to even
	end
	// hidden bit adds one to the field, carries fall through naturally
	word = (longint'(te - 1) << 23) + q;
	if (word >= (longint'(255) << 23))
		return {2'b11, sgn, 8'hff, 23'h0};
	return {1'b0, rem != 0, sgn, word[30:0]};
endfunction

`endif

/* tb/fmul_tb.sv */
/* testbench for the multiply pipe. random and directed operands go in one
   per cycle, a behavioral model predicts each result in issue order */
`timescale 1ns/1ps

module fmul_tb;

	import fmul_pkg::*;

	localparam int N_NORM    = 200;
	localparam int N_DEN     = 60;
	localparam int N_OVF     = 20;
	localparam int N_SPEC    = 12;
	localparam int N_GAP     = 60;   // ops with up to 3 idle cycles ahead
	localparam int RST_CYC   = 2;
	localparam int SEC_IDLE  = 6;
	localparam int N_OPS     = N_NORM + N_DEN + N_OVF + N_SPEC + N_GAP;
	localparam int CYC_LIMIT = RST_CYC + N_OPS + 3 * N_GAP + 6 * SEC_IDLE + 4 + 20;

	// nan, inf times zero, inf, signed zero, denormal partners
	localparam logic [31:0] SPEC_A [N_SPEC] = '{32'h7fc00000, 32'h7f800001, 32'hff800000,
		32'h00000000, 32'h7f800000, 32'hff800000, 32'h80000000, 32'h00000000,
		32'h3f800000, 32'h7f800000, 32'h7fffffff, 32'h80000000};
	localparam logic [31:0] SPEC_B [N_SPEC] = '{32'h3f800000, 32'h00000000, 32'h00000000,
		32'h7f800000, 32'hbf800000, 32'h00000001, 32'h3f800000, 32'h80400000,
		32'h3f800000, 32'h7f800000, 32'h7f800000, 32'h7f7fffff};

	logic        rclk, i_arst_n, i_valid, o_valid, o_inexact, o_overflow;
	fmul_word_t  i_op_a, i_op_b, o_result;
	logic [15:0] lfsr_state;
	logic [33:0] exp_q [$];   // {overflow, inexact, word}
	logic [33:0] exp_cur;
	logic [3:0]  vld_hist;    // i_valid seen on earlier falling edges
	int          mism_errs  = 0;
	int          other_errs = 0;
	int          cyc;

	`include "fmul_ref.svh"

	fmul_top dut (
		.rclk       (rclk),
		.i_arst_n   (i_arst_n),
		.i_valid    (i_valid),
		.i_op_a     (i_op_a),
		.i_op_b     (i_op_b),
		.o_valid    (o_valid),
		.o_result   (o_result),
		.o_inexact  (o_inexact),
		.o_overflow (o_overflow)
	);

	initial begin
		rclk = 1'b0;
		forever #50 rclk = ~rclk;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);   // one step per bit
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// exponent drawn from e_lo + e_bits random bits
	function automatic fmul_word_t rand_word(input int e_lo, input int e_bits);
		fmul_word_t w;
		w.sign = 1'(take_bits(1));
		w.exp  = 8'(e_lo + int'(take_bits(e_bits)));
		w.frac = 23'(take_bits(FRAC_W));
		return w;
	endfunction

	task automatic check_word(input string name, input fmul_word_t want, input fmul_word_t got);
		if (got !== want) begin
			$display("Mismatch %s expected %h actual %h", name, 32'(want), 32'(got));
			mism_errs++;
		end
	endtask

	task automatic check_flag(input string name, input logic want, input logic got);
		if (got !== want) begin
			$display("Mismatch %s expected %h actual %h", name, want, got);
			mism_errs++;
		end
	endtask

	task automatic issue(input fmul_word_t a, input fmul_word_t b);
		@(posedge rclk);
		i_valid <= 1'b1;
		i_op_a  <= a;
		i_op_b  <= b;
		exp_q.push_back(ref_fmul(a, b));   // same order as the pipe
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge rclk);
			i_valid <= 1'b0;
		end
	endtask

	task automatic print_counts();
		$display("error counts: mismatches %0d, other %0d", mism_errs, other_errs);
	endtask

	//////////////////////////////
	// compare on falling edge
	//////////////////////////////

	always @(negedge rclk) begin
		if (i_arst_n === 1'b1) begin
			check_flag("o_valid", vld_hist[3], o_valid);   // four edges after the strobe
			if (o_valid) begin
				if (exp_q.size() == 0) begin
					$display("o_valid seen with no operation outstanding");
					other_errs++;
				end else begin
					exp_cur = exp_q.pop_front();
					check_word("o_result", exp_cur[31:0], o_result);
					check_flag("o_inexact", exp_cur[32], o_inexact);
					check_flag("o_overflow", exp_cur[33], o_overflow);
				end
			end
			vld_hist <= {vld_hist[2:0], i_valid};
		end else begin
			vld_hist <= '0;   // pipe comes out of reset empty
		end
	end

	// watchdog
	initial begin
		cyc = 0;
		while (cyc < CYC_LIMIT) begin
			@(posedge rclk);
			cyc++;
		end
		$display("run did not finish within %0d cycles", CYC_LIMIT);
		other_errs++;
		print_counts();
		$display("ERRORS FOUND");
		$finish;
	end

	//////////////////////////////
	// stimulus
	//////////////////////////////

	initial begin
		i_arst_n   = 1'b0;
		i_valid    = 1'b0;
		i_op_a     = '0;
		i_op_b     = '0;
		lfsr_state = 16'd12;
		repeat (RST_CYC) @(posedge rclk);
		i_arst_n <= 1'b1;
		idle(SEC_IDLE);   // o_valid must stay low here
		for (int i = 0; i < N_NORM; i++)
			issue(rand_word(64, 7), rand_word(64, 7));   // back to back normals
		idle(SEC_IDLE);
		for (int i = 0; i < N_DEN; i++) begin
			if (i % 3 == 2)
				issue(rand_word(0, 0), rand_word(0, 0));   // underflows to zero
			else
				issue(rand_word(0, 0), rand_word((i % 3 == 0) ? 1 : 127, 7));
		end
		idle(SEC_IDLE);
		issue(32'h7f7fffff, 32'h40000000);   // max normal times two
		for (int i = 1; i < N_OVF; i++)
			issue(rand_word(190, 6), rand_word(190, 6));
		idle(SEC_IDLE);
		for (int i = 0; i < N_SPEC; i++)
			issue(SPEC_A[i], SPEC_B[i]);
		idle(SEC_IDLE);
		for (int i = 0; i < N_GAP; i++) begin
			idle(int'(take_bits(2)));   // 0 to 3 bubble cycles
			issue(rand_word(64, 7), rand_word(64, 7));
		end
		idle(SEC_IDLE);
		while (exp_q.size() != 0)
			@(negedge rclk);
		repeat (SEC_IDLE) @(negedge rclk);   // no stray strobes after drain
		print_counts();
		if (mism_errs + other_errs == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* hdl/fmul_top.sv */
/* single-precision multiply pipe top. one operation per cycle in,
   one rounded result out four edges after the operand strobe */
`timescale 1ns/1ps

module fmul_top (
	input  logic                 rclk,
	input  logic                 i_arst_n,
	input  logic                 i_valid,      // one cycle operand strobe
	input  fmul_pkg::fmul_word_t i_op_a,
	input  fmul_pkg::fmul_word_t i_op_b,
	output logic                 o_valid,      // one cycle result strobe
	output fmul_pkg::fmul_word_t o_result,
	output logic                 o_inexact,
	output logic                 o_overflow
);

	import fmul_pkg::*;

	logic           unp_valid;
	fmul_unpacked_t unp_item;   // classified operands
	logic           stg_valid;
	fmul_unpacked_t stg_item;   // one stage later

	// operand registers and decode
	fmul_unpack u_unpack (
		.rclk     (rclk),
		.i_arst_n (i_arst_n),
		.i_valid  (i_valid),
		.i_op_a   (i_op_a),
		.i_op_b   (i_op_b),
		.o_valid  (unp_valid),
		.o_item   (unp_item)
	);

	// decode to multiply boundary
	fmul_stage_reg #(
		.PAYLOAD_T (fmul_unpacked_t)
	) u_unp_reg (
		.rclk     (rclk),
		.i_arst_n (i_arst_n),
		.i_valid  (unp_valid),
		.i_item   (unp_item),
		.o_valid  (stg_valid),
		.o_item   (stg_item)
	);

	// multiply, normalize, round
	fmul_round u_round (
		.rclk       (rclk),
		.i_arst_n   (i_arst_n),
		.i_valid    (stg_valid),
		.i_item     (stg_item),
		.o_valid    (o_valid),
		.o_result   (o_result),
		.o_inexact  (o_inexact),
		.o_overflow (o_overflow)
	);

endmodule

/* hdl/fmul_round.sv */
/* back half of the multiply pipe. forms the significand product, then
   post-normalizes, denormalizes, rounds to nearest even and registers */
`timescale 1ns/1ps

module fmul_round (
	input  logic                     rclk,
	input  logic                     i_arst_n,
	input  logic                     i_valid,
	input  fmul_pkg::fmul_unpacked_t i_item,
	output logic                     o_valid,
	output fmul_pkg::fmul_word_t     o_result,
	output logic                     o_inexact,
	output logic                     o_overflow
);

	import fmul_pkg::*;

	fmul_product_t                 prod_d;
	fmul_product_t                 prod_q;
	logic                          prod_vld;
	logic [$clog2(PROD_W+1)-1:0]   lz;
	logic                          prod_zero;

	logic [PROD_W-1:0]             norm;       // hidden bit one below the msb
	logic                          norm_stk;   // bit lost on the right shift
	logic signed [EXP_INT_W-1:0]   e_norm;
	logic [EXP_INT_W-1:0]          dn_amt;     // denormalize distance
	logic [2*PROD_W-1:0]           dn_wide;
	logic [PROD_W-1:0]             fin_sig;
	logic                          fin_stk;
	logic [EXP_INT_W-1:0]          e_field;    // zero for denormals
	logic                          guard;
	logic                          sticky;
	logic                          round_up;
	logic [EXP_INT_W+FRAC_W-1:0]   rnd;        // exponent and fraction rounded together
	logic [EXP_INT_W-1:0]          e_rnd;
	fmul_word_t                    res_d;
	logic                          nx_d;
	logic                          of_d;

	//////////////////////////////
	// multiply and product reg
	//////////////////////////////

	always_comb begin
		prod_d.sign = i_item.sign;
		prod_d.cls  = i_item.cls;
		prod_d.exp  = i_item.exp;
		prod_d.prod = i_item.sig_a * i_item.sig_b;   // 1.x times 1.x lands in [1,4)
	end

	fmul_stage_reg #(
		.PAYLOAD_T (fmul_product_t)
	) u_prod_reg (
		.rclk     (rclk),
		.i_arst_n (i_arst_n),
		.i_valid  (i_valid),
		.i_item   (prod_d),
		.o_valid  (prod_vld),
		.o_item   (prod_q)
	);

	fmul_lead0 #(
		.WIDTH (PROD_W)
	) u_lead0 (
		.i_din   (prod_q.prod),
		.o_lead0 (lz),
		.o_zero  (prod_zero)
	);

	//////////////////////////////
	// post-normalize
	//////////////////////////////

	always_comb begin
		if (prod_q.prod[PROD_W-1]) begin   // product in [2,4)
			norm     = prod_q.prod >> 1;
			norm_stk = prod_q.prod[0];
			e_norm   = prod_q.exp + EXP_INT_W'(1);
		end else begin
			norm     = prod_q.prod << (lz - 1'b1);   // lz is at least one here
			norm_stk = 1'b0;
			e_norm   = prod_q.exp - EXP_INT_W'(lz) + EXP_INT_W'(1);
		end
	end

	// gradual underflow
	always_comb begin
		dn_amt = EXP_INT_W'(1) - e_norm;
		if (dn_amt > EXP_INT_W'(PROD_W))
			dn_amt = EXP_INT_W'(PROD_W);   // everything goes to sticky
		dn_wide = {norm, {PROD_W{1'b0}}} >> dn_amt;
		if (e_norm < 1) begin
			fin_sig = dn_wide[2*PROD_W-1 -: PROD_W];
			fin_stk = norm_stk | (|dn_wide[PROD_W-1:0]);
			e_field = '0;
		end else begin
			fin_sig = norm;
			fin_stk = norm_stk;
			e_field = e_norm;
		end
	end

	//////////////////////////////
	// round to nearest even
	//////////////////////////////

	assign guard    = fin_sig[PROD_W-3-FRAC_W];
	assign sticky   = fin_stk | (|fin_sig[PROD_W-4-FRAC_W:0]);
	assign round_up = guard & (sticky | fin_sig[PROD_W-2-FRAC_W]);   // tie goes to even
	// carry out of the fraction bumps the exponent
	assign rnd      = {e_field, fin_sig[PROD_W-3 -: FRAC_W]}
		+ (EXP_INT_W+FRAC_W)'(round_up);
	assign e_rnd    = rnd[FRAC_W +: EXP_INT_W];

	always_comb begin
		res_d      = '0;
		res_d.sign = prod_q.sign;
		nx_d       = 1'b0;
		of_d       = 1'b0;
		case (prod_q.cls)
			CLS_NAN: begin
				res_d = QNAN_WORD;   // sign dropped
			end
			CLS_INF: begin
				res_d.exp = '1;
			end
			CLS_ZERO: ;   // signed zero from the default
			default: begin
				if (prod_zero) begin
					res_d.exp = '0;   // never expected for numbers
				end else if (e_rnd >= EXP_INT_W'({EXP_W{1'b1}})) begin
					res_d.exp = '1;   // overflow to signed inf
					of_d      = 1'b1;
					nx_d      = 1'b1;
				end else begin
					res_d.exp  = e_rnd[EXP_W-1:0];
					res_d.frac = rnd[FRAC_W-1:0];
					nx_d       = guard | sticky;
				end
			end
		endcase
	end

	//////////////////////////////
	// result register
	//////////////////////////////

	always_ff @(posedge rclk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_valid    <= 1'b0;
			o_result   <= '0;
			o_inexact  <= 1'b0;
			o_overflow <= 1'b0;
		end else begin
			o_valid <= prod_vld;
			if (prod_vld) begin   // outputs hold between strobes
				o_result   <= res_d;
				o_inexact  <= nx_d;
				o_overflow <= of_d;
			end
		end
	end

	// unpack guarantees two nonzero significands for numbers
	a_num_nonzero: assert property (@(posedge rclk) disable iff (!i_arst_n)
		(prod_vld && prod_q.cls == CLS_NUM) |-> !prod_zero);

endmodule

/* hdl/fmul_unpack.sv */
/* operand input stage of the multiply pipe. registers both operands on the
   strobe, classifies them and pre-normalizes denormal significands */
`timescale 1ns/1ps

module fmul_unpack (
	input  logic                     rclk,
	input  logic                     i_arst_n,
	input  logic                     i_valid,
	input  fmul_pkg::fmul_word_t     i_op_a,
	input  fmul_pkg::fmul_word_t     i_op_b,
	output logic                     o_valid,
	output fmul_pkg::fmul_unpacked_t o_item
);

	import fmul_pkg::*;

	fmul_word_t                  op_q [2];     // index 0 is a, 1 is b
	logic                        valid_q;

	logic                        den    [2];   // exponent field zero
	logic [SIG_W-1:0]            raw    [2];   // significand with hidden bit
	logic [$clog2(SIG_W+1)-1:0]  lz     [2];
	logic                        is_zero[2];
	logic                        is_inf [2];
	logic                        is_nan [2];
	logic [SIG_W-1:0]            sig    [2];   // normalized significand
	logic signed [EXP_INT_W-1:0] eff    [2];   // effective biased exponent

	//////////////////////////////
	// input registers
	//////////////////////////////

	always_ff @(posedge rclk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			valid_q <= 1'b0;
			op_q[0] <= '0;
			op_q[1] <= '0;
		end else begin
			valid_q <= i_valid;
			if (i_valid) begin   // hold last operands when idle
				op_q[0] <= i_op_a;
				op_q[1] <= i_op_b;
			end
		end
	end

	//////////////////////////////
	// per operand decode
	//////////////////////////////

	for (genvar g = 0; g < 2; g++) begin : g_op
		assign den[g] = (op_q[g].exp == '0);
		assign raw[g] = {~den[g], op_q[g].frac};   // hidden bit only for normals

		fmul_lead0 #(
			.WIDTH (SIG_W)
		) u_lead0 (
			.i_din   (raw[g]),
			.o_lead0 (lz[g]),
			.o_zero  (is_zero[g])
		);

		assign is_inf[g] = (op_q[g].exp == '1) && (op_q[g].frac == '0);
		assign is_nan[g] = (op_q[g].exp == '1) && (op_q[g].frac != '0);

		// normals have lz 0 so one shift covers both kinds
		assign sig[g] = is_zero[g] ? '0 : raw[g] << lz[g];
		// denormal scale is 2^(1-bias) before the shift
		assign eff[g] = EXP_INT_W'(den[g] ? EXP_W'(1) : op_q[g].exp) - EXP_INT_W'(lz[g]);
	end

	//////////////////////////////
	// class, sign and exponent
	//////////////////////////////

	always_comb begin
		o_item.sign  = op_q[0].sign ^ op_q[1].sign;
		o_item.sig_a = sig[0];
		o_item.sig_b = sig[1];
		o_item.exp   = eff[0] + eff[1] - EXP_INT_W'(EXP_BIAS);   // may run negative

		if (is_nan[0] || is_nan[1])
			o_item.cls = CLS_NAN;
		else if ((is_inf[0] && is_zero[1]) || (is_zero[0] && is_inf[1]))
			o_item.cls = CLS_NAN;   // inf times zero is invalid
		else if (is_inf[0] || is_inf[1])
			o_item.cls = CLS_INF;
		else if (is_zero[0] || is_zero[1])
			o_item.cls = CLS_ZERO;
		else
			o_item.cls = CLS_NUM;
	end

	assign o_valid = valid_q;

	// leading one must land in the hidden bit for every finite nonzero pair
	a_num_normalized: assert property (@(posedge rclk) disable iff (!i_arst_n)
		(o_valid && o_item.cls == CLS_NUM) |-> (o_item.sig_a[SIG_W-1] && o_item.sig_b[SIG_W-1]));

endmodule

/* hdl/fmul_stage_reg.sv */
/* one-deep pipeline register for any payload type. the valid bit tracks
   the input strobe every cycle and the item loads only on a strobe */
`timescale 1ns/1ps

module fmul_stage_reg #(
	parameter type PAYLOAD_T = fmul_pkg::fmul_unpacked_t
) (
	input  logic     rclk,
	input  logic     i_arst_n,
	input  logic     i_valid,
	input  PAYLOAD_T i_item,
	output logic     o_valid,
	output PAYLOAD_T o_item
);

	always_ff @(posedge rclk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_valid <= 1'b0;   // empty after reset
			o_item  <= '0;
		end else begin
			o_valid <= i_valid;   // no stall so just follow
			if (i_valid)
				o_item <= i_item;   // hold across bubbles
		end
	end

	// strobe leaving the stage is always resolved
	a_valid_known: assert property (@(posedge rclk) disable iff (!i_arst_n)
		!$isunknown(o_valid));

endmodule

/* hdl/fmul_lead0.sv */
/* leading-zero counter of any width, used for operand
   pre-normalization and product post-normalization */
`timescale 1ns/1ps

module fmul_lead0 #(
	parameter int WIDTH = 24
) (
	input  logic [WIDTH-1:0]             i_din,
	output logic [$clog2(WIDTH+1)-1:0]   o_lead0,   // WIDTH when input is zero
	output logic                         o_zero     // all bits clear
);

	// priority encode from the lsb up so the highest set bit wins
	always_comb begin
		o_lead0 = ($clog2(WIDTH+1))'(WIDTH);
		for (int i = 0; i < WIDTH; i++) begin
			if (i_din[i])
				o_lead0 = ($clog2(WIDTH+1))'(WIDTH - 1 - i);   // zeros above bit i
		end
	end

	assign o_zero = ~|i_din;   // caller can skip the shift

endmodule

/* hdl/fmul_pkg.sv */
/* shared widths, constants and pipeline payload types for the
   single-precision multiply pipe */

package fmul_pkg;

	//////////////////////////////
	// field and datapath widths
	//////////////////////////////

	localparam int FRAC_W    = 23;   // stored fraction
	localparam int EXP_W     = 8;    // exponent field
	localparam int SIG_W     = 24;   // fraction plus hidden bit
	localparam int PROD_W    = 48;   // full significand product
	localparam int EXP_BIAS  = 127;
	localparam int EXP_INT_W = 10;   // signed internal exponent

	// packed ieee single word
	typedef struct packed {
		logic             sign;
		logic [EXP_W-1:0] exp;
		logic [FRAC_W-1:0] frac;
	} fmul_word_t;

	// canonical quiet nan
	localparam fmul_word_t QNAN_WORD = 32'h7fc0_0000;

	// operand / product class
	typedef enum logic [1:0] {
		CLS_NUM  = 2'd0,
		CLS_ZERO = 2'd1,
		CLS_INF  = 2'd2,
		CLS_NAN  = 2'd3
	} fmul_class_e;

	//////////////////////////////
	// stage payloads
	//////////////////////////////

	// unpack stage out
	typedef struct packed {
		logic                        sign;   // product sign
		fmul_class_e                 cls;
		logic signed [EXP_INT_W-1:0] exp;    // unbiased sum, rebiased once
		logic [SIG_W-1:0]            sig_a;  // msb set for numbers
		logic [SIG_W-1:0]            sig_b;
	} fmul_unpacked_t;

	// product register payload
	typedef struct packed {
		logic                        sign;
		fmul_class_e                 cls;
		logic signed [EXP_INT_W-1:0] exp;
		logic [PROD_W-1:0]           prod;   // raw significand product
	} fmul_product_t;

endpackage
